// ==== verilog/pcie_dma_pkg.sv ====
/* Widths, TLP codes and FSM encodings shared by the receive DMA path.
   The packet-buffer ring is fixed at 512 quadwords; one host page only. */
package pcie_dma_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int QWORD_W      = 64;                // Buffer word and local link
    localparam int RX_BUF_AW    = 9;                 // 512 qwords in the ring
    localparam int CHUNK_QW_W   = 6;                 // Holds 0..32
    localparam int MAX_CHUNK_QW = 32;                // 256 B payload cap
    localparam int REG_OFS_W    = 4;                 // Low byte-address bits of BAR0

    // ------------------------------------------------------------------------
    // TLP fields
    // ------------------------------------------------------------------------
    localparam logic [7:0] TLP_MWR64_FMT_TYPE = 8'h60;   // 4DW MWr with data
    localparam logic [3:0] BE_ALL             = 4'hf;    // Whole DW enabled

    typedef enum logic [REG_OFS_W-1:0] {
        PAGE_ADDR_LO = 4'h0,                         // Page base [31:0]
        PAGE_ADDR_HI = 4'h4,                         // Page base [63:32]
        PAGE_ARM     = 4'h8,                         // Bit 0 arms, clears offset
        IRQ_ENABLE   = 4'hc                          // Bit 0 enables interrupts
    } reg_ofs_e;

    typedef enum logic [7:0] {
        MWR32_1DW = 8'h40                            // 3DW MWr from the host
    } rx_fmt_e;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_HDR,                                     // DW0/DW1 beat
        ENG_ADDR,                                    // 64-bit address beat
        ENG_DATA,
        ENG_ACK                                      // Wait for req to drop
    } eng_state_e;

    typedef enum logic [1:0] {
        TRIG_IDLE,
        TRIG_REQ,
        TRIG_WAIT_LOW                                // Ack must fall first
    } trig_state_e;

endpackage

// ==== verilog/rx_page_regs.sv ====
/* Accepts only 2-beat 1-DW MWr32 on BAR0; other TLPs are dropped silently.
   The receive link is never back-pressured. */
`timescale 1ns/1ps

module rx_page_regs (
    input  logic                                trn_clk,
    input  logic                                rst,
    input  logic [pcie_dma_pkg::QWORD_W-1:0]    trn_rd,
    input  logic                                trn_rsof_n,
    input  logic                                trn_reof_n,
    input  logic                                trn_rsrc_rdy_n,
    input  logic [6:0]                          trn_rbar_hit_n,
    output logic                                trn_rdst_rdy_n,
    output logic [pcie_dma_pkg::QWORD_W-1:0]    page_base,
    output logic                                page_valid,
    output logic                                page_arm_pulse,
    output logic                                irq_enable
);

    logic [7:0]             hdr_fmt;            // fmt/type from DW0
    logic                   hdr_len_one;        // DW0 length is 1
    logic                   mid_tlp;            // Sof seen, eof not yet
    logic                   rx_beat;
    logic                   wr_hit;
    pcie_dma_pkg::reg_ofs_e reg_ofs;

    assign trn_rdst_rdy_n = 1'b0;               // Always listen
    assign rx_beat        = ~trn_rsrc_rdy_n;
    assign reg_ofs        = pcie_dma_pkg::reg_ofs_e'(trn_rd[32 +: pcie_dma_pkg::REG_OFS_W]);

    // Second beat of a register write to BAR0
    assign wr_hit = rx_beat && !trn_reof_n && trn_rsof_n && mid_tlp && hdr_len_one
                 && hdr_fmt == pcie_dma_pkg::MWR32_1DW && !trn_rbar_hit_n[0];

    always_ff @(posedge trn_clk) begin
        if (rst) begin
            hdr_fmt        <= '0;
            hdr_len_one    <= 1'b0;
            mid_tlp        <= 1'b0;
            page_base      <= '0;
            page_valid     <= 1'b0;
            page_arm_pulse <= 1'b0;
            irq_enable     <= 1'b0;
        end else begin
            page_arm_pulse <= 1'b0;
            if (rx_beat && !trn_rsof_n) begin
                hdr_fmt     <= trn_rd[63:56];
                hdr_len_one <= trn_rd[41:32] == 10'd1;
                mid_tlp     <= trn_reof_n;      // Single-beat TLPs end here
            end else if (rx_beat && !trn_reof_n) begin
                mid_tlp     <= 1'b0;
            end
            if (wr_hit) begin
                case (reg_ofs)
                    pcie_dma_pkg::PAGE_ADDR_LO: page_base[31:0]  <= trn_rd[31:0];
                    pcie_dma_pkg::PAGE_ADDR_HI: page_base[63:32] <= trn_rd[31:0];
                    pcie_dma_pkg::PAGE_ARM: begin
                        page_valid     <= trn_rd[0];
                        page_arm_pulse <= trn_rd[0];    // Engine restarts at the base
                    end
                    pcie_dma_pkg::IRQ_ENABLE:   irq_enable <= trn_rd[0];
                    default: ;                          // Unknown offset
                endcase
            end
        end
    end

endmodule

// ==== verilog/rx_tlp_trigger.sv ====
/* One chunk in flight; chunk_qw holds from request until the ack is seen.
   Max payload codes above 256 B are clipped to MAX_CHUNK_QW. */
`timescale 1ns/1ps

module rx_tlp_trigger (
    input  logic                                    trn_clk,
    input  logic                                    rst,
    input  logic [15:0]                             cfg_dcommand,
    input  logic                                    page_valid,
    input  logic [pcie_dma_pkg::RX_BUF_AW:0]        commited_wr_addr,
    input  logic [pcie_dma_pkg::RX_BUF_AW:0]        commited_rd_addr,
    output logic                                    chunk_req,
    input  logic                                    chunk_ack,
    output logic [pcie_dma_pkg::CHUNK_QW_W-1:0]     chunk_qw
);

    pcie_dma_pkg::trig_state_e          state;
    logic [pcie_dma_pkg::RX_BUF_AW:0]   buffered_qw;    // Ring occupancy
    logic [11:0]                        mps_qw;         // Max payload in qwords
    logic [11:0]                        limit_qw;
    logic [11:0]                        next_qw;

    assign buffered_qw = commited_wr_addr - commited_rd_addr;   // Wraps with the extra bit
    assign mps_qw      = 12'd16 << cfg_dcommand[7:5];           // 128 B << field
    assign limit_qw    = (mps_qw < 12'(pcie_dma_pkg::MAX_CHUNK_QW)) ?
                         mps_qw : 12'(pcie_dma_pkg::MAX_CHUNK_QW);
    assign next_qw     = (12'(buffered_qw) < limit_qw) ? 12'(buffered_qw) : limit_qw;
    assign chunk_req   = state == pcie_dma_pkg::TRIG_REQ;

    always_ff @(posedge trn_clk) begin
        if (rst) begin
            state    <= pcie_dma_pkg::TRIG_IDLE;
            chunk_qw <= '0;
        end else begin
            case (state)
                pcie_dma_pkg::TRIG_IDLE:
                    if (page_valid && buffered_qw != '0 && !chunk_ack) begin
                        state    <= pcie_dma_pkg::TRIG_REQ;
                        chunk_qw <= next_qw[pcie_dma_pkg::CHUNK_QW_W-1:0];
                    end
                pcie_dma_pkg::TRIG_REQ:
                    if (chunk_ack) state <= pcie_dma_pkg::TRIG_WAIT_LOW;    // Drop req
                pcie_dma_pkg::TRIG_WAIT_LOW:
                    if (!chunk_ack) state <= pcie_dma_pkg::TRIG_IDLE;
                default: state <= pcie_dma_pkg::TRIG_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/rx_wr_tlp_engine.sv ====
/* Buffer read latency must be exactly one cycle; data beats come straight
   from rx_rd_data. No page-overflow check: the host re-arms in time. */
`timescale 1ns/1ps

module rx_wr_tlp_engine (
    input  logic                                    trn_clk,
    input  logic                                    rst,
    output logic [pcie_dma_pkg::QWORD_W-1:0]        trn_td,
    output logic [7:0]                              trn_trem_n,
    output logic                                    trn_tsof_n,
    output logic                                    trn_teof_n,
    output logic                                    trn_tsrc_rdy_n,
    input  logic                                    trn_tdst_rdy_n,
    input  logic [7:0]                              cfg_bus_number,
    input  logic [4:0]                              cfg_device_number,
    input  logic [2:0]                              cfg_function_number,
    input  logic [pcie_dma_pkg::QWORD_W-1:0]        page_base,
    input  logic                                    page_arm_pulse,
    input  logic                                    chunk_req,
    input  logic [pcie_dma_pkg::CHUNK_QW_W-1:0]     chunk_qw,
    output logic                                    chunk_ack,
    output logic [pcie_dma_pkg::RX_BUF_AW:0]        commited_rd_addr,
    output logic [pcie_dma_pkg::RX_BUF_AW-1:0]      rx_rd_addr,
    input  logic [pcie_dma_pkg::QWORD_W-1:0]        rx_rd_data
);

    pcie_dma_pkg::eng_state_e               state;
    logic [pcie_dma_pkg::CHUNK_QW_W-1:0]    beats_left;     // Data beats still to go
    logic [pcie_dma_pkg::RX_BUF_AW-1:0]     rd_word;        // Word now on rx_rd_data
    logic [pcie_dma_pkg::QWORD_W-1:0]       page_ofs;       // Bytes already in the page
    logic [pcie_dma_pkg::QWORD_W-1:0]       hdr_qw;
    logic                                   beat_acc;
    logic                                   data_acc;

    assign beat_acc   = !trn_tsrc_rdy_n && !trn_tdst_rdy_n;
    assign data_acc   = beat_acc && state == pcie_dma_pkg::ENG_DATA;
    assign rx_rd_addr = data_acc ? rd_word + 1'b1 : rd_word;   // Fetch next on accept

    // DW0: fmt/type, length 2n DWs. DW1: requester id, tag 0, both BEs
    assign hdr_qw = {pcie_dma_pkg::TLP_MWR64_FMT_TYPE, 14'd0, 3'd0, chunk_qw, 1'b0,
                     cfg_bus_number, cfg_device_number, cfg_function_number,
                     8'd0, pcie_dma_pkg::BE_ALL, pcie_dma_pkg::BE_ALL};

    // ------------------------------------------------------------------------
    // Outbound beat, held by state under back-pressure
    // ------------------------------------------------------------------------
    assign trn_trem_n     = 8'h00;                          // Always full qwords
    assign trn_tsrc_rdy_n = !(state inside {pcie_dma_pkg::ENG_HDR, pcie_dma_pkg::ENG_ADDR,
                                            pcie_dma_pkg::ENG_DATA});
    assign trn_tsof_n     = state != pcie_dma_pkg::ENG_HDR;
    assign trn_teof_n     = !(state == pcie_dma_pkg::ENG_DATA && beats_left == 1'b1);

    always_comb begin
        case (state)
            pcie_dma_pkg::ENG_HDR:  trn_td = hdr_qw;
            pcie_dma_pkg::ENG_ADDR: trn_td = page_base + page_ofs;
            pcie_dma_pkg::ENG_DATA: trn_td = rx_rd_data;
            default:                trn_td = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Chunk FSM and pointers
    // ------------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (rst) begin
            state            <= pcie_dma_pkg::ENG_IDLE;
            beats_left       <= '0;
            rd_word          <= '0;
            page_ofs         <= '0;
            chunk_ack        <= 1'b0;
            commited_rd_addr <= '0;
        end else begin
            if (data_acc) rd_word <= rd_word + 1'b1;
            case (state)
                pcie_dma_pkg::ENG_IDLE:
                    if (chunk_req) begin
                        beats_left <= chunk_qw;
                        state      <= pcie_dma_pkg::ENG_HDR;
                    end
                pcie_dma_pkg::ENG_HDR:
                    if (beat_acc) state <= pcie_dma_pkg::ENG_ADDR;
                pcie_dma_pkg::ENG_ADDR:
                    if (beat_acc) state <= pcie_dma_pkg::ENG_DATA;
                pcie_dma_pkg::ENG_DATA:
                    if (beat_acc) begin
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == 1'b1) begin       // Eof beat taken
                            state            <= pcie_dma_pkg::ENG_ACK;
                            chunk_ack        <= 1'b1;
                            commited_rd_addr <= commited_rd_addr + chunk_qw;
                            page_ofs         <= page_ofs + {chunk_qw, 3'b000};
                        end
                    end
                pcie_dma_pkg::ENG_ACK:
                    if (!chunk_req) begin
                        chunk_ack <= 1'b0;
                        state     <= pcie_dma_pkg::ENG_IDLE;
                    end
                default: state <= pcie_dma_pkg::ENG_IDLE;
            endcase
            if (page_arm_pulse) page_ofs <= '0;             // Re-arm wins over advance
        end
    end

endmodule

// ==== verilog/rx_interrupt_gen.sv ====
/* Legacy INTx through the core handshake; chunks done while one is pending
   merge into it. Disabled interrupts are dropped, not held. */
`timescale 1ns/1ps

module rx_interrupt_gen (
    input  logic    trn_clk,
    input  logic    rst,
    input  logic    irq_enable,
    input  logic    chunk_ack,
    output logic    cfg_interrupt_n,
    input  logic    cfg_interrupt_rdy_n
);

    logic ack_d;                                // Last chunk_ack
    logic ack_rise;                             // One per finished chunk
    logic pending;

    assign ack_rise        = chunk_ack && !ack_d;
    assign cfg_interrupt_n = !pending;          // Held low until the core takes it

    always_ff @(posedge trn_clk) begin
        if (rst) begin
            ack_d   <= 1'b0;
            pending <= 1'b0;
        end else begin
            ack_d <= chunk_ack;
            if (pending && !cfg_interrupt_rdy_n) begin
                pending <= 1'b0;                // Core accepted it
            end else if (ack_rise && irq_enable) begin
                pending <= 1'b1;                // Merges when already set
            end
        end
    end

endmodule

// ==== verilog/pcie_endpoint_driver.sv ====
/* Receive DMA path of the NIC endpoint: BAR0 registers, chunk trigger,
   MWr engine and interrupt. Sole driver of the transmit local link. */
`timescale 1ns/1ps

module pcie_endpoint_driver (
    input  logic                                    trn_clk,
    input  logic                                    rst,
    // Rx local link
    input  logic [pcie_dma_pkg::QWORD_W-1:0]        trn_rd,
    input  logic                                    trn_rsof_n,
    input  logic                                    trn_reof_n,
    input  logic                                    trn_rsrc_rdy_n,
    input  logic [6:0]                              trn_rbar_hit_n,
    output logic                                    trn_rdst_rdy_n,
    // Tx local link
    output logic [pcie_dma_pkg::QWORD_W-1:0]        trn_td,
    output logic [7:0]                              trn_trem_n,
    output logic                                    trn_tsof_n,
    output logic                                    trn_teof_n,
    output logic                                    trn_tsrc_rdy_n,
    input  logic                                    trn_tdst_rdy_n,
    // Config space
    input  logic [15:0]                             cfg_dcommand,
    input  logic [7:0]                              cfg_bus_number,
    input  logic [4:0]                              cfg_device_number,
    input  logic [2:0]                              cfg_function_number,
    output logic                                    cfg_interrupt_n,
    input  logic                                    cfg_interrupt_rdy_n,
    // Packet buffer
    input  logic [pcie_dma_pkg::RX_BUF_AW:0]        rx_commited_wr_addr,
    output logic [pcie_dma_pkg::RX_BUF_AW:0]        rx_commited_rd_addr,
    output logic [pcie_dma_pkg::RX_BUF_AW-1:0]      rx_rd_addr,
    input  logic [pcie_dma_pkg::QWORD_W-1:0]        rx_rd_data
);

    logic [pcie_dma_pkg::QWORD_W-1:0]       page_base;
    logic                                   page_valid;
    logic                                   page_arm_pulse;
    logic                                   irq_enable;
    logic                                   chunk_req;
    logic                                   chunk_ack;
    logic [pcie_dma_pkg::CHUNK_QW_W-1:0]    chunk_qw;

    rx_page_regs rx_page_regs_mod (
        .trn_clk(trn_clk),                              // I
        .rst(rst),                                      // I
        .trn_rd(trn_rd),                                // I [63:0]
        .trn_rsof_n(trn_rsof_n),                        // I
        .trn_reof_n(trn_reof_n),                        // I
        .trn_rsrc_rdy_n(trn_rsrc_rdy_n),                // I
        .trn_rbar_hit_n(trn_rbar_hit_n),                // I [6:0]
        .trn_rdst_rdy_n(trn_rdst_rdy_n),                // O
        .page_base(page_base),                          // O [63:0]
        .page_valid(page_valid),                        // O
        .page_arm_pulse(page_arm_pulse),                // O
        .irq_enable(irq_enable)                         // O
    );

    rx_tlp_trigger rx_tlp_trigger_mod (
        .trn_clk(trn_clk),                              // I
        .rst(rst),                                      // I
        .cfg_dcommand(cfg_dcommand),                    // I [15:0]
        .page_valid(page_valid),                        // I
        .commited_wr_addr(rx_commited_wr_addr),         // I [9:0]
        .commited_rd_addr(rx_commited_rd_addr),         // I [9:0]
        .chunk_req(chunk_req),                          // O
        .chunk_ack(chunk_ack),                          // I
        .chunk_qw(chunk_qw)                             // O [5:0]
    );

    rx_wr_tlp_engine rx_wr_tlp_engine_mod (
        .trn_clk(trn_clk),                              // I
        .rst(rst),                                      // I
        .trn_td(trn_td),                                // O [63:0]
        .trn_trem_n(trn_trem_n),                        // O [7:0]
        .trn_tsof_n(trn_tsof_n),                        // O
        .trn_teof_n(trn_teof_n),                        // O
        .trn_tsrc_rdy_n(trn_tsrc_rdy_n),                // O
        .trn_tdst_rdy_n(trn_tdst_rdy_n),                // I
        .cfg_bus_number(cfg_bus_number),                // I [7:0]
        .cfg_device_number(cfg_device_number),          // I [4:0]
        .cfg_function_number(cfg_function_number),      // I [2:0]
        .page_base(page_base),                          // I [63:0]
        .page_arm_pulse(page_arm_pulse),                // I
        .chunk_req(chunk_req),                          // I
        .chunk_qw(chunk_qw),                            // I [5:0]
        .chunk_ack(chunk_ack),                          // O
        .commited_rd_addr(rx_commited_rd_addr),         // O [9:0]
        .rx_rd_addr(rx_rd_addr),                        // O [8:0]
        .rx_rd_data(rx_rd_data)                         // I [63:0]
    );

    rx_interrupt_gen rx_interrupt_gen_mod (
        .trn_clk(trn_clk),                              // I
        .rst(rst),                                      // I
        .irq_enable(irq_enable),                        // I
        .chunk_ack(chunk_ack),                          // I
        .cfg_interrupt_n(cfg_interrupt_n),              // O
        .cfg_interrupt_rdy_n(cfg_interrupt_rdy_n)       // I
    );

endmodule

// ==== sim/pcie_endpoint_driver_props.sv ====
/* Handshake and framing checks, bound into the top level where the engine,
   trigger and interrupt signals meet. Reset disables every property. */
`timescale 1ns/1ps

module pcie_endpoint_driver_props (
    input  logic                                trn_clk,
    input  logic                                rst,
    input  logic                                chunk_req,
    input  logic                                chunk_ack,
    input  logic [pcie_dma_pkg::QWORD_W-1:0]    trn_td,
    input  logic                                trn_tsof_n,
    input  logic                                trn_teof_n,
    input  logic                                trn_tsrc_rdy_n,
    input  logic                                trn_tdst_rdy_n,
    input  logic                                cfg_interrupt_n,
    input  logic                                cfg_interrupt_rdy_n
);

    // Ack only answers a live request
    ack_needs_req: assert property (@(posedge trn_clk) disable iff (rst)
        $rose(chunk_ack) |-> chunk_req)
        else $error("chunk_ack rose without chunk_req");

    // Request held until the engine acks
    req_held: assert property (@(posedge trn_clk) disable iff (rst)
        $fell(chunk_req) |-> chunk_ack)
        else $error("chunk_req dropped before chunk_ack");

    // Stalled beat keeps data and framing
    beat_held: assert property (@(posedge trn_clk) disable iff (rst)
        (!trn_tsrc_rdy_n && trn_tdst_rdy_n) |=>
        (!trn_tsrc_rdy_n && $stable(trn_td) && $stable(trn_tsof_n) && $stable(trn_teof_n)))
        else $error("tx beat changed under back-pressure");

    // INTx held until the core takes it
    irq_held: assert property (@(posedge trn_clk) disable iff (rst)
        (!cfg_interrupt_n && cfg_interrupt_rdy_n) |=> !cfg_interrupt_n)
        else $error("cfg_interrupt_n released before cfg_interrupt_rdy_n");

endmodule

bind pcie_endpoint_driver pcie_endpoint_driver_props props_chk (
    .trn_clk(trn_clk),
    .rst(rst),
    .chunk_req(chunk_req),
    .chunk_ack(chunk_ack),
    .trn_td(trn_td),
    .trn_tsof_n(trn_tsof_n),
    .trn_teof_n(trn_teof_n),
    .trn_tsrc_rdy_n(trn_tsrc_rdy_n),
    .trn_tdst_rdy_n(trn_tdst_rdy_n),
    .cfg_interrupt_n(cfg_interrupt_n),
    .cfg_interrupt_rdy_n(cfg_interrupt_rdy_n)
);

// ==== sim/tb_pcie_endpoint_driver.sv ====
/* Buffer model answers one cycle after rx_rd_addr. Total traffic stays
   under 512 qwords, so the ring pointers never wrap during the run. */
`timescale 1ns/1ps

module tb_pcie_endpoint_driver;

    localparam int BUF_WORDS      = 512;
    // 2 + n beats per chunk: 10 | 32 32 6 | 5 3 | 32 8 | 4
    localparam int CHUNK_BEATS    = 12 + 34 + 34 + 8 + 7 + 5 + 34 + 10 + 6;
    localparam int TIMEOUT_CYCLES = CHUNK_BEATS * 4 + 200;

    logic           trn_clk = 1'b0;
    logic           rst;
    logic [63:0]    trn_rd;
    logic           trn_rsof_n;
    logic           trn_reof_n;
    logic           trn_rsrc_rdy_n;
    logic [6:0]     trn_rbar_hit_n;
    logic           trn_rdst_rdy_n;
    logic [63:0]    trn_td;
    logic [7:0]     trn_trem_n;
    logic           trn_tsof_n;
    logic           trn_teof_n;
    logic           trn_tsrc_rdy_n;
    logic           trn_tdst_rdy_n = 1'b0;
    logic [15:0]    cfg_dcommand;
    logic [7:0]     cfg_bus_number;
    logic [4:0]     cfg_device_number;
    logic [2:0]     cfg_function_number;
    logic           cfg_interrupt_n;
    logic           cfg_interrupt_rdy_n;
    logic [9:0]     rx_commited_wr_addr;
    logic [9:0]     rx_commited_rd_addr;
    logic [8:0]     rx_rd_addr;
    logic [63:0]    rx_rd_data = '0;

    logic [63:0]    rx_buf [BUF_WORDS];             // Packet buffer contents
    logic [8:0]     rd_addr_q = '0;                 // Address the buffer latched
    integer         seed = 50;
    int             cycles = 0;
    logic [63:0]    exp_base = 64'h0000_0012_3450_0000;
    int             exp_wr = 0;                     // Qwords committed
    int             exp_rd = 0;                     // Qwords seen on the link
    int             arm_rd = 0;                     // exp_rd when the page was armed
    int             beat_idx = 0;                   // Beat within current TLP
    int             chunk_n = 0;
    int             chunks_done = 0;
    int             irq_falls = 0;
    logic           irq_prev = 1'b1;
    logic           irq_allowed = 1'b0;             // Interrupts enabled by the host

    pcie_endpoint_driver uut (.*);

    always #20 trn_clk = ~trn_clk;                  // 40 ns period

    // ------------------------------------------------------------------------
    // Reference model and check
    // ------------------------------------------------------------------------
    function automatic int ref_chunk_qw(input int buffered, input logic [15:0] dcmd);
        int n;
        n = buffered;
        if (n > (16 << dcmd[7:5])) n = 16 << dcmd[7:5];    // Max payload, 128 B units
        if (n > 32) n = 32;                                 // 256 B cap
        return n;
    endfunction

    function automatic logic [63:0] ref_beat(input logic [63:0] base, input logic [63:0] ofs,
                                             input int rd_ptr, input int buffered,
                                             input logic [15:0] dcmd, input int idx);
        int n;
        n = ref_chunk_qw(buffered, dcmd);
        case (idx)
            0: return {8'h60, 14'd0, 10'(2 * n),           // 4DW MWr, length in DWs
                       cfg_bus_number, cfg_device_number, cfg_function_number,
                       8'd0, 8'hff};                        // Tag 0, all BEs
            1: return base + ofs;
            default: return rx_buf[(rd_ptr + idx - 2) % BUF_WORDS];
        endcase
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s, got %h expected %h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // Buffer model, back-pressure, monitor, timeout
    // ------------------------------------------------------------------------
    always @(posedge trn_clk) rd_addr_q <= rx_rd_addr;         // One-cycle read latency
    always @(negedge trn_clk) rx_rd_data = rx_buf[rd_addr_q];
    always @(negedge trn_clk) trn_tdst_rdy_n = ($random(seed) % 4) == 0;   // ~25% stalls

    always @(posedge trn_clk) begin
        if (!rst) begin
            if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin      // Accepted beat
                if (beat_idx == 0) chunk_n = ref_chunk_qw(exp_wr - exp_rd, cfg_dcommand);
                check(trn_td, ref_beat(exp_base, 64'((exp_rd - arm_rd) * 8), exp_rd,
                                       exp_wr - exp_rd, cfg_dcommand, beat_idx),
                      $sformatf("beat %0d of chunk %0d", beat_idx, chunks_done));
                check(trn_tsof_n, beat_idx != 0, "tsof flag");
                check(trn_teof_n, beat_idx != chunk_n + 1, "teof flag");
                check(trn_trem_n, 8'h00, "trem");
                if (beat_idx == chunk_n + 1) begin
                    exp_rd      = exp_rd + chunk_n;
                    chunks_done = chunks_done + 1;
                    beat_idx    = 0;
                end else begin
                    beat_idx = beat_idx + 1;
                end
            end
            check(trn_rdst_rdy_n, 1'b0, "rx link back-pressured");
            if (!irq_allowed) check(cfg_interrupt_n, 1'b1, "interrupt while disabled");
            if (irq_prev && !cfg_interrupt_n) irq_falls = irq_falls + 1;
            irq_prev = cfg_interrupt_n;
        end
    end

    always @(posedge trn_clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: traffic not finished after %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------
    task automatic raw_write(input logic [7:0] fmt, input logic [3:0] ofs,
                             input logic [31:0] data, input logic [6:0] bar_hit_n);
        @(negedge trn_clk);
        trn_rd         = {fmt, 14'd0, 10'd1, 32'h0000_000f};   // DW0, DW1
        trn_rsof_n     = 1'b0;
        trn_rsrc_rdy_n = 1'b0;
        trn_rbar_hit_n = bar_hit_n;
        @(negedge trn_clk);
        trn_rd         = {28'hf00_0000, ofs, data};           // Address, data
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b0;
        @(negedge trn_clk);
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rbar_hit_n = 7'h7f;
        @(negedge trn_clk);                                     // Register settled
    endtask

    task automatic reg_write(input logic [3:0] ofs, input logic [31:0] data);
        raw_write(8'(pcie_dma_pkg::MWR32_1DW), ofs, data, 7'h7e);   // BAR0 hit
    endtask

    task automatic advance_wr(input int n);
        @(negedge trn_clk);
        exp_wr              = exp_wr + n;
        rx_commited_wr_addr = 10'(exp_wr);
    endtask

    task automatic wait_drained();
        while (exp_rd != exp_wr || uut.chunk_ack) @(negedge trn_clk);
        check(rx_commited_rd_addr, 10'(exp_wr), "committed read pointer");
    endtask

    task automatic pulse_irq_rdy();
        @(negedge trn_clk);
        cfg_interrupt_rdy_n = 1'b0;
        @(negedge trn_clk);
        cfg_interrupt_rdy_n = 1'b1;
        @(negedge trn_clk);
        check(cfg_interrupt_n, 1'b1, "interrupt released after rdy");
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        for (int i = 0; i < BUF_WORDS; i++) begin
            rx_buf[i] = {$random(seed), $random(seed)};
        end
        rst                 = 1'b1;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7f;
        cfg_dcommand        = 16'h0000;             // 128 B max payload
        cfg_bus_number      = 8'h05;
        cfg_device_number   = 5'h02;
        cfg_function_number = 3'h1;
        cfg_interrupt_rdy_n = 1'b1;
        rx_commited_wr_addr = '0;
        repeat (4) @(negedge trn_clk);
        rst = 1'b0;

        // Words wait while the page is not armed
        advance_wr(10);
        repeat (20) @(negedge trn_clk);
        reg_write(pcie_dma_pkg::PAGE_ADDR_LO, exp_base[31:0]);
        reg_write(pcie_dma_pkg::PAGE_ADDR_HI, exp_base[63:32]);
        repeat (8) @(negedge trn_clk);
        check(beat_idx + chunks_done, 0, "TLP sent before the page was armed");

        // Arm, one 10-qword TLP
        arm_rd = exp_rd;
        reg_write(pcie_dma_pkg::PAGE_ARM, 32'h1);
        wait_drained();
        check(chunks_done, 1, "chunks after arming");

        // 512 B max payload, capped at 256 B
        cfg_dcommand = 16'h0040;
        advance_wr(70);
        wait_drained();
        check(chunks_done, 4, "chunks for 70 qwords");

        // Bad writes leave the base alone
        raw_write(8'(pcie_dma_pkg::MWR32_1DW), 4'h2, 32'hdead_beef, 7'h7e);   // Unknown offset
        raw_write(8'(pcie_dma_pkg::MWR32_1DW), 4'h0, 32'hbad0_0000, 7'h7d);   // No BAR0 hit
        raw_write(8'h00, 4'h0, 32'hbad1_0000, 7'h7e);                          // Wrong fmt
        advance_wr(5);
        wait_drained();
        arm_rd = exp_rd;                            // Re-arm restarts at the base
        reg_write(pcie_dma_pkg::PAGE_ARM, 32'h1);
        advance_wr(3);
        wait_drained();

        // Two chunks merge into one pending interrupt
        irq_allowed = 1'b1;
        reg_write(pcie_dma_pkg::IRQ_ENABLE, 32'h1);
        advance_wr(40);
        wait_drained();
        check(cfg_interrupt_n, 1'b0, "interrupt pending after chunks");
        check(irq_falls, 1, "merged interrupt count");
        pulse_irq_rdy();
        advance_wr(4);
        wait_drained();
        check(cfg_interrupt_n, 1'b0, "interrupt pending after last chunk");
        check(irq_falls, 2, "interrupt count after second handshake");
        pulse_irq_rdy();
        check(chunks_done, 9, "total chunks");

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== pcie_endpoint_driver.f ====
verilog/pcie_dma_pkg.sv
verilog/rx_page_regs.sv
verilog/rx_tlp_trigger.sv
verilog/rx_wr_tlp_engine.sv
verilog/rx_interrupt_gen.sv
verilog/pcie_endpoint_driver.sv
sim/pcie_endpoint_driver_props.sv
sim/tb_pcie_endpoint_driver.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the verdict.
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal \
    --top-module tb_pcie_endpoint_driver \
    --Mdir obj_dir -o tb_pcie_endpoint_driver \
    -f pcie_endpoint_driver.f &&
./obj_dir/tb_pcie_endpoint_driver ||
{
    echo "Simulation build or run failed"
    exit 1
}
